/* source/flash_dump_pkg.sv */
/*
 * flash dump console, shared definitions
 * widths, record types, flash opcodes and default timing
 */

`default_nettype none

package flash_dump_pkg;

	// --------------------------------------------------------------------------
	// widths
	// --------------------------------------------------------------------------
	typedef logic [7:0] byte_t;

	// three address bytes, sent msb first
	typedef logic [23:0] flash_addr_t;

	// --------------------------------------------------------------------------
	// records passed between blocks
	// --------------------------------------------------------------------------
	typedef struct packed {
		logic write;
		flash_addr_t addr;
		byte_t wdata;
	} flash_req_t;

	typedef struct packed {
		flash_addr_t addr;
		byte_t data;
	} dump_rec_t;

	// spi flash command bytes
	localparam byte_t op_read = 8'h03;
	localparam byte_t op_write_enable = 8'h06;
	localparam byte_t op_page_program = 8'h02;

	// byte that gets programmed on a write request
	localparam byte_t write_char = 8'h23;

	// 200 ms at 27 MHz
	localparam int default_settle_cycles = 5_400_000;
	// 27 MHz / 115200 baud
	localparam int default_clks_per_bit = 234;

endpackage

`default_nettype wire

/* source/spi_flash_master.sv */
/*
 * spi flash master, mode 0, sck at half the system clock
 * runs byte read, or write enable followed by page program
 */

`default_nettype none

module spi_flash_master (
	input wire clk27,
	input wire rst,

	// request side
	input wire flash_dump_pkg::flash_req_t req,
	input wire req_valid,
	output wire req_ready,
	output flash_dump_pkg::byte_t rdata,
	output logic done,

	// flash pins
	output logic flash_clk,
	output logic flash_sel,
	output wire flash_mosi,
	input wire flash_miso
);

	typedef enum logic [2:0] {
		st_idle, st_wren, st_gap, st_xfer, st_done
	} state_t;

	state_t state;
	flash_dump_pkg::flash_req_t req_q;

	// opcode, address and data, shifted out msb first
	logic [39:0] sr;
	logic [5:0] bit_idx;
	wire [5:0] last_bit = (state == st_wren) ? 6'd7 : 6'd39;
	wire shifting = (state == st_wren) || (state == st_xfer);

	assign req_ready = (state == st_idle);
	assign flash_mosi = sr[39];

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			state <= st_idle;
			sr <= '0;
			bit_idx <= '0;
			flash_clk <= 1'b0;
			flash_sel <= 1'b1;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
			st_idle: begin
				if (req_valid) begin
					flash_sel <= 1'b0;
					bit_idx <= '0;
					if (req.write) begin
						sr <= {flash_dump_pkg::op_write_enable, 32'h0};
						state <= st_wren;
					end else begin
						sr <= {flash_dump_pkg::op_read, req.addr, 8'h00};
						state <= st_xfer;
					end
				end
			end

			st_wren, st_xfer: begin
				if (!flash_clk) begin
					// rising edge, flash samples mosi
					flash_clk <= 1'b1;
				end else begin
					// falling edge, next bit onto mosi
					flash_clk <= 1'b0;
					if (bit_idx == last_bit) begin
						flash_sel <= 1'b1;
						bit_idx <= '0;
						state <= (state == st_wren) ? st_gap : st_done;
					end else begin
						bit_idx <= bit_idx + 6'd1;
						sr <= {sr[38:0], 1'b0};
					end
				end
			end

			// chip select stays high for two cycles between commands
			st_gap: begin
				if (bit_idx == 6'd1) begin
					sr <= {flash_dump_pkg::op_page_program, req_q.addr, req_q.wdata};
					bit_idx <= '0;
					flash_sel <= 1'b0;
					state <= st_xfer;
				end else begin
					bit_idx <= bit_idx + 6'd1;
				end
			end

			st_done: begin
				done <= 1'b1;
				state <= st_idle;
			end

			default: state <= st_idle;
			endcase
		end
	end

	// request hold and read data capture
	always_ff @(posedge clk27) begin
		if (req_valid && req_ready)
			req_q <= req;
		// data byte arrives during the last 8 clocks
		if (shifting && !flash_clk && bit_idx >= 6'd32)
			rdata <= {rdata[6:0], flash_miso};
	end

endmodule

`default_nettype wire

/* source/uart_tx.sv */
/*
 * uart transmitter, 8N1
 * one character in flight, ready only while idle
 */

`default_nettype none

module uart_tx #(
	parameter int clks_per_bit = flash_dump_pkg::default_clks_per_bit
) (
	input wire clk27,
	input wire rst,
	input wire flash_dump_pkg::byte_t char,
	input wire char_valid,
	output wire char_ready,
	output wire serial_tx
);

	localparam int timer_w = $clog2(clks_per_bit);

	logic busy;
	logic [timer_w-1:0] timer;
	logic [3:0] bits_left;

	// stop bit, data lsb first, start bit
	logic [9:0] frame;

	assign char_ready = !busy;
	assign serial_tx = frame[0];

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			timer <= '0;
			bits_left <= '0;
			frame <= '1;
		end else if (!busy) begin
			if (char_valid) begin
				frame <= {1'b1, char, 1'b0};
				busy <= 1'b1;
				timer <= '0;
				bits_left <= 4'd10;
			end
		end else if (timer == timer_w'(clks_per_bit - 1)) begin
			// end of bit time, line idles high afterwards
			timer <= '0;
			frame <= {1'b1, frame[9:1]};
			bits_left <= bits_left - 4'd1;
			if (bits_left == 4'd1)
				busy <= 1'b0;
		end else begin
			timer <= timer + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/dump_line_formatter.sv */
/*
 * console line formatter
 * address in binary, raw byte, binary and hex value, 45 characters per line
 */

`default_nettype none

module dump_line_formatter (
	input wire clk27,
	input wire rst,

	input wire flash_dump_pkg::dump_rec_t rec,
	input wire rec_valid,
	output wire rec_ready,

	output flash_dump_pkg::byte_t char,
	output wire char_valid,
	input wire char_ready,
	output logic line_done
);

	typedef enum logic [3:0] {
		fld_idle, fld_addr, fld_usc, fld_sep, fld_raw,
		fld_bin, fld_prefix, fld_hex, fld_eol
	} field_t;

	field_t field, next_field;
	flash_dump_pkg::dump_rec_t rec_q;
	logic [4:0] bit_cnt;
	logic [1:0] dig_cnt, last_dig;
	wire step = char_valid && char_ready;

	function automatic flash_dump_pkg::byte_t hex_char(input logic [3:0] nib);
		if (nib < 4'd10)
			return flash_dump_pkg::byte_t'(8'h30 + nib);
		return flash_dump_pkg::byte_t'(8'h37 + nib);
	endfunction

	assign rec_ready = (field == fld_idle);
	assign char_valid = (field != fld_idle);

	// --------------------------------------------------------------------------
	// character of the current field
	// --------------------------------------------------------------------------
	always_comb begin
		last_dig = 2'd1;
		next_field = fld_idle;
		char = 8'h00;
		case (field)
		fld_addr: char = rec_q.addr[5'd23 - bit_cnt] ? "1" : "0";
		fld_usc: char = "_";
		fld_sep: begin
			char = (dig_cnt == 2'd0) ? ":" : " ";
			next_field = fld_raw;
		end
		fld_raw: begin
			char = (dig_cnt == 2'd0) ? rec_q.data : " ";
			next_field = fld_bin;
		end
		fld_bin: char = rec_q.data[3'd7 - bit_cnt[2:0]] ? "1" : "0";
		fld_prefix: begin
			last_dig = 2'd2;
			char = (dig_cnt == 2'd0) ? " " : (dig_cnt == 2'd1) ? "0" : "x";
			next_field = fld_hex;
		end
		fld_hex: begin
			char = hex_char((dig_cnt == 2'd0) ? rec_q.data[7:4] : rec_q.data[3:0]);
			next_field = fld_eol;
		end
		// cr then lf
		fld_eol: char = (dig_cnt == 2'd0) ? 8'h0d : 8'h0a;
		default: char = 8'h00;
		endcase
	end

	// --------------------------------------------------------------------------
	// field sequencing
	// --------------------------------------------------------------------------
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			field <= fld_idle;
			bit_cnt <= '0;
			dig_cnt <= '0;
			line_done <= 1'b0;
		end else begin
			line_done <= 1'b0;
			case (field)
			fld_idle: begin
				if (rec_valid)
					field <= fld_addr;
			end
			fld_addr: begin
				if (step) begin
					if (bit_cnt == 5'd23) begin
						bit_cnt <= '0;
						field <= fld_sep;
					end else begin
						bit_cnt <= bit_cnt + 5'd1;
						// byte groups split by underscores
						if (bit_cnt == 5'd7 || bit_cnt == 5'd15)
							field <= fld_usc;
					end
				end
			end
			fld_usc: begin
				if (step)
					field <= fld_addr;
			end
			fld_bin: begin
				if (step) begin
					if (bit_cnt == 5'd7) begin
						bit_cnt <= '0;
						field <= fld_prefix;
					end else begin
						bit_cnt <= bit_cnt + 5'd1;
					end
				end
			end
			default: begin
				// fixed multi-character fields
				if (step) begin
					if (dig_cnt == last_dig) begin
						dig_cnt <= '0;
						field <= next_field;
						line_done <= (field == fld_eol);
					end else begin
						dig_cnt <= dig_cnt + 2'd1;
					end
				end
			end
			endcase
		end
	end

	always_ff @(posedge clk27) begin
		if (rec_valid && rec_ready)
			rec_q <= rec;
	end

endmodule

`default_nettype wire

/* source/dump_sequencer.sv */
/*
 * dump sequencer
 * settle, optional write of one byte, then read and print each address in turn
 */

`default_nettype none

module dump_sequencer #(
	parameter int settle_cycles = flash_dump_pkg::default_settle_cycles
) (
	input wire clk27,
	input wire rst,
	input wire write_req,

	output flash_dump_pkg::flash_req_t flash_req,
	output wire flash_req_valid,
	input wire flash_req_ready,
	input wire flash_done,
	input wire flash_dump_pkg::byte_t rdata,

	output flash_dump_pkg::dump_rec_t rec,
	output wire rec_valid,
	input wire rec_ready,
	input wire line_done
);

	localparam int cnt_w = $clog2(settle_cycles + 1);

	typedef enum logic [3:0] {
		s_settle, s_write_req, s_write_wait, s_post_settle, s_read_req,
		s_read_wait, s_print_req, s_print_wait, s_next
	} state_t;

	state_t state;
	flash_dump_pkg::flash_addr_t addr;
	flash_dump_pkg::byte_t data_q;
	logic [cnt_w-1:0] settle_cnt;
	wire settle_end = (settle_cnt == cnt_w'(settle_cycles - 1));

	assign flash_req_valid = (state == s_write_req) || (state == s_read_req);
	assign flash_req = '{write: (state == s_write_req), addr: addr,
		wdata: flash_dump_pkg::write_char};
	assign rec_valid = (state == s_print_req);
	assign rec = '{addr: addr, data: data_q};

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			state <= s_settle;
			addr <= '0;
			settle_cnt <= '0;
		end else begin
			case (state)
			// write_req only counts here, so one write per reset
			s_settle: begin
				settle_cnt <= settle_end ? '0 : settle_cnt + 1'b1;
				if (settle_end)
					state <= write_req ? s_write_req : s_read_req;
			end
			s_write_req: if (flash_req_ready) state <= s_write_wait;
			s_write_wait: if (flash_done) state <= s_post_settle;
			// no status polling, just give the flash time to program
			s_post_settle: begin
				settle_cnt <= settle_end ? '0 : settle_cnt + 1'b1;
				if (settle_end)
					state <= s_read_req;
			end
			s_read_req: if (flash_req_ready) state <= s_read_wait;
			s_read_wait: if (flash_done) state <= s_print_req;
			s_print_req: if (rec_ready) state <= s_print_wait;
			s_print_wait: if (line_done) state <= s_next;
			s_next: begin
				addr <= addr + 1'b1;
				state <= s_read_req;
			end
			default: state <= s_settle;
			endcase
		end
	end

	always_ff @(posedge clk27) begin
		if (state == s_read_wait && flash_done)
			data_q <= rdata;
	end

endmodule

`default_nettype wire

/* source/flash_dump_top.sv */
/*
 * flash dump console top level
 * reads the spi flash byte by byte and prints each byte on the uart
 */

`default_nettype none

module flash_dump_top #(
	parameter int settle_cycles = flash_dump_pkg::default_settle_cycles,
	parameter int clks_per_bit = flash_dump_pkg::default_clks_per_bit
) (
	input wire clk27,
	input wire rst,
	input wire write_req,
	output wire flash_clk,
	output wire flash_sel,
	output wire flash_mosi,
	input wire flash_miso,
	output wire serial_tx
);

	wire flash_dump_pkg::flash_req_t flash_req;
	wire flash_req_valid, flash_req_ready, flash_done;
	wire flash_dump_pkg::byte_t rdata;

	wire flash_dump_pkg::dump_rec_t rec;
	wire rec_valid, rec_ready, line_done;

	wire flash_dump_pkg::byte_t char;
	wire char_valid, char_ready;

	dump_sequencer #(.settle_cycles(settle_cycles)) seq (
		.clk27(clk27), .rst(rst), .write_req(write_req),
		.flash_req(flash_req), .flash_req_valid(flash_req_valid),
		.flash_req_ready(flash_req_ready), .flash_done(flash_done), .rdata(rdata),
		.rec(rec), .rec_valid(rec_valid), .rec_ready(rec_ready), .line_done(line_done)
	);

	spi_flash_master flash (
		.clk27(clk27), .rst(rst),
		.req(flash_req), .req_valid(flash_req_valid), .req_ready(flash_req_ready),
		.rdata(rdata), .done(flash_done),
		.flash_clk(flash_clk), .flash_sel(flash_sel),
		.flash_mosi(flash_mosi), .flash_miso(flash_miso)
	);

	dump_line_formatter fmt (
		.clk27(clk27), .rst(rst),
		.rec(rec), .rec_valid(rec_valid), .rec_ready(rec_ready),
		.char(char), .char_valid(char_valid), .char_ready(char_ready),
		.line_done(line_done)
	);

	uart_tx #(.clks_per_bit(clks_per_bit)) tx (
		.clk27(clk27), .rst(rst),
		.char(char), .char_valid(char_valid), .char_ready(char_ready),
		.serial_tx(serial_tx)
	);

endmodule

`default_nettype wire

/* bench/spi_flash_model.sv */
/*
 * behavioral spi serial flash, mode 0
 * byte read, write enable and page program on a small byte memory
 */

`default_nettype none

module spi_flash_model (
	input wire flash_clk,
	input wire flash_sel,
	input wire flash_mosi,
	output logic flash_miso
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int mem_words = 4096;

	// low address bits select the byte
	flash_dump_pkg::byte_t mem [0:mem_words-1];
	int program_count = 0;

	logic [39:0] shift_in = '0;
	int bit_cnt = 0;
	logic write_enabled = 1'b0;
	flash_dump_pkg::byte_t read_byte = '0;

	initial flash_miso = 1'b0;

	task automatic fill_random();
		for (int i = 0; i < mem_words; i++)
			mem[i] = flash_dump_pkg::byte_t'($urandom);
	endtask

	always @(negedge flash_sel) begin
		bit_cnt = 0;
		shift_in = '0;
	end

	// opcode and address come in on the rising edge
	always @(posedge flash_clk) begin
		if (!flash_sel) begin
			shift_in = {shift_in[38:0], flash_mosi};
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == 32 && shift_in[31:24] == flash_dump_pkg::op_read)
				read_byte = mem[shift_in[11:0]];
		end
	end

	// read data out on the falling edge, msb first
	always @(negedge flash_clk) begin
		if (!flash_sel && bit_cnt >= 32 && bit_cnt < 40)
			flash_miso <= read_byte[39 - bit_cnt];
	end

	// a command takes effect when chip select rises
	always @(posedge flash_sel) begin
		if (bit_cnt == 8 && shift_in[7:0] == flash_dump_pkg::op_write_enable) begin
			write_enabled = 1'b1;
		end else if (bit_cnt == 40 && shift_in[39:32] == flash_dump_pkg::op_page_program
				&& write_enabled) begin
			// programming only clears bits
			mem[shift_in[19:8]] = mem[shift_in[19:8]] & shift_in[7:0];
			program_count = program_count + 1;
			write_enabled = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* bench/tb_flash_dump.sv */
/*
 * flash dump console testbench
 * uart receiver, reference console line and line comparison
 */

`default_nettype none

module tb_flash_dump;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int settle_cycles = 200;
	localparam int clks_per_bit = 8;
	localparam int line_len = 45;
	localparam int line_bits = 8 * line_len;
	localparam int line_timeout = 10000;

	logic clk27;
	logic rst;
	logic write_req;
	wire flash_clk, flash_sel, flash_mosi, flash_miso, serial_tx;

	int unsigned seed_sink;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	bit aborted = 1'b0;

	// uart receiver state
	flash_dump_pkg::byte_t rx_chars[$];
	flash_dump_pkg::byte_t rx_char;
	flash_dump_pkg::byte_t rx_prev = '0;
	bit rx_busy = 1'b0;
	int rx_tick;
	int rx_bit;
	int lines_seen = 0;
	int lines_taken = 0;

	flash_dump_top #(.settle_cycles(settle_cycles), .clks_per_bit(clks_per_bit)) UUT (
		.clk27(clk27), .rst(rst), .write_req(write_req),
		.flash_clk(flash_clk), .flash_sel(flash_sel),
		.flash_mosi(flash_mosi), .flash_miso(flash_miso),
		.serial_tx(serial_tx)
	);

	spi_flash_model flash_chip (
		.flash_clk(flash_clk), .flash_sel(flash_sel),
		.flash_mosi(flash_mosi), .flash_miso(flash_miso)
	);

	initial begin
		clk27 = 1'b0;
		forever #50 clk27 = ~clk27;
	end

	// --------------------------------------------------------------------------
	// uart receiver sampling mid-bit on the falling clock edge
	// --------------------------------------------------------------------------
	always @(negedge clk27) begin
		if (rst) begin
			rx_busy = 1'b0;
			rx_chars.delete();
			rx_prev = '0;
			lines_seen = 0;
		end else if (!rx_busy) begin
			if (serial_tx == 1'b0) begin
				rx_busy = 1'b1;
				rx_tick = 0;
			end
		end else begin
			rx_tick = rx_tick + 1;
			if (rx_tick % clks_per_bit == clks_per_bit / 2 - 1) begin
				rx_bit = rx_tick / clks_per_bit;
				if (rx_bit == 0 && serial_tx !== 1'b0) begin
					$display("uart start bit did not last half a bit time");
					error_count++;
					rx_busy = 1'b0;
				end else if (rx_bit >= 1 && rx_bit <= 8) begin
					rx_char[rx_bit - 1] = serial_tx;
				end else if (rx_bit == 9) begin
					if (serial_tx !== 1'b1) begin
						$display("uart stop bit was low after character %h", rx_char);
						error_count++;
					end
					rx_chars.push_back(rx_char);
					// only cr followed by lf ends a line since the raw byte can be any value
					if (rx_char == 8'h0a && rx_prev == 8'h0d)
						lines_seen++;
					rx_prev = rx_char;
					rx_busy = 1'b0;
				end
			end
		end
	end

	// --------------------------------------------------------------------------
	// reference line and field decoding
	// --------------------------------------------------------------------------
	function automatic logic [line_bits-1:0] add_char(input logic [line_bits-1:0] s,
			input flash_dump_pkg::byte_t c);
		return {s[line_bits-9:0], c};
	endfunction

	function automatic flash_dump_pkg::byte_t char_at(input logic [line_bits-1:0] line,
			input int pos);
		return line[8 * (line_len - 1 - pos) +: 8];
	endfunction

	function automatic logic [line_bits-1:0] expected_line(
			input flash_dump_pkg::flash_addr_t addr, input flash_dump_pkg::byte_t data);
		logic [line_bits-1:0] s;
		logic [127:0] digits;
		int i;
		digits = "0123456789ABCDEF";
		s = '0;
		for (i = 23; i >= 0; i--) begin
			s = add_char(s, addr[i] ? "1" : "0");
			if (i == 16 || i == 8)
				s = add_char(s, "_");
		end
		s = add_char(s, ":");
		s = add_char(s, " ");
		s = add_char(s, data);
		s = add_char(s, " ");
		for (i = 7; i >= 0; i--)
			s = add_char(s, data[i] ? "1" : "0");
		s = add_char(s, " ");
		s = add_char(s, "0");
		s = add_char(s, "x");
		s = add_char(s, digits[8 * (15 - data[7:4]) +: 8]);
		s = add_char(s, digits[8 * (15 - data[3:0]) +: 8]);
		s = add_char(s, 8'h0d);
		s = add_char(s, 8'h0a);
		return s;
	endfunction

	// bit 8 flags a character outside the field's alphabet
	function automatic logic [8:0] decode_bin(input logic [line_bits-1:0] line);
		logic [8:0] v;
		flash_dump_pkg::byte_t c;
		int i;
		v = '0;
		for (i = 0; i < 8; i++) begin
			c = char_at(line, 30 + i);
			if (c == "1")
				v[7 - i] = 1'b1;
			else if (c != "0")
				v[8] = 1'b1;
		end
		return v;
	endfunction

	function automatic logic [8:0] decode_hex(input logic [line_bits-1:0] line);
		logic [8:0] v;
		logic [3:0] nib;
		flash_dump_pkg::byte_t c;
		int i;
		v = '0;
		for (i = 0; i < 2; i++) begin
			c = char_at(line, 41 + i);
			nib = 4'h0;
			if (c >= "0" && c <= "9")
				nib = 4'(c - "0");
			else if (c >= "A" && c <= "F")
				nib = 4'(c - "A" + 8'd10);
			else
				v[8] = 1'b1;
			v[7:0] = {v[3:0], nib};
		end
		return v;
	endfunction

	// --------------------------------------------------------------------------
	// checks and waits
	// --------------------------------------------------------------------------
	task automatic check(input string name, input logic [line_bits-1:0] expected,
			input logic [line_bits-1:0] actual, input bit text);
		if (expected !== actual) begin
			error_count++;
			if (text)
				$display("[FAIL] %s: expected \"%s\" actual \"%s\"", name,
					expected[line_bits-1:16], actual[line_bits-1:16]);
			else
				$display("[FAIL] %s: expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (error_count == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d error(s)", name, error_count - errs_before);
		end
	endtask

	// reset for 10 cycles and then watch the idle pins for watch more cycles
	task automatic reset_and_watch(input logic wr, input int watch, output logic [2:0] first_bad);
		int i;
		first_bad = 3'b110;
		@(posedge clk27);
		rst <= 1'b1;
		write_req <= wr;
		for (i = 0; i < 10 + watch; i++) begin
			@(negedge clk27);
			if ({serial_tx, flash_sel, flash_clk} !== 3'b110 && first_bad == 3'b110)
				first_bad = {serial_tx, flash_sel, flash_clk};
			@(posedge clk27);
			if (i == 9)
				rst <= 1'b0;
		end
		lines_taken = 0;
	endtask

	task automatic get_line(input string what, output logic [line_bits-1:0] line,
			output int len);
		int waited;
		flash_dump_pkg::byte_t c;
		flash_dump_pkg::byte_t prev;
		line = '0;
		len = 0;
		waited = 0;
		c = '0;
		if (aborted)
			return;
		while (lines_seen == lines_taken && waited < line_timeout) begin
			@(posedge clk27);
			waited++;
		end
		if (lines_seen == lines_taken) begin
			$display("timeout: no console line for %s within %0d cycles", what, line_timeout);
			error_count++;
			aborted = 1'b1;
			return;
		end
		lines_taken++;
		do begin
			prev = c;
			c = rx_chars.pop_front();
			line = add_char(line, c);
			len++;
		end while (c != 8'h0a || prev != 8'h0d);
	endtask

	task automatic wait_program(input int limit);
		int waited;
		waited = 0;
		if (aborted)
			return;
		while (flash_chip.program_count == 0 && waited < limit) begin
			@(posedge clk27);
			waited++;
		end
		if (flash_chip.program_count == 0) begin
			$display("timeout: the flash saw no page program within %0d cycles", limit);
			error_count++;
			aborted = 1'b1;
		end
	endtask

	// --------------------------------------------------------------------------
	// test sequence
	// --------------------------------------------------------------------------
	initial begin
		logic [line_bits-1:0] line;
		logic [line_bits-1:0] seq_lines [1:8];
		logic [2:0] pins;
		flash_dump_pkg::byte_t orig0, raw;
		int a, len, errs;

		rst = 1'b1;
		write_req = 1'b0;
		seed_sink = $urandom(32'h8076_16d5);
		flash_chip.fill_random();
		orig0 = flash_chip.mem[0];

		errs = error_count;
		reset_and_watch(1'b0, settle_cycles - 10, pins);
		check("idle pins {serial_tx, flash_sel, flash_clk}", 3'b110, pins, 1'b0);
		end_test("idle after reset", errs);

		errs = error_count;
		get_line("address 0", line, len);
		if (!aborted) begin
			check("line for address 0", expected_line(24'h0, flash_chip.mem[0]), line, 1'b1);
			check("length of line 0", line_len, len, 1'b0);
		end
		end_test("first line", errs);

		errs = error_count;
		for (a = 1; a <= 8; a++) begin
			get_line($sformatf("address %0d", a), line, len);
			seq_lines[a] = line;
			if (!aborted) begin
				check($sformatf("line for address %0d", a),
					expected_line(flash_dump_pkg::flash_addr_t'(a), flash_chip.mem[a]),
					line, 1'b1);
				check($sformatf("length of line %0d", a), line_len, len, 1'b0);
			end
		end
		end_test("address sequence", errs);

		// binary and hex fields must give back the raw byte
		errs = error_count;
		if (!aborted) begin
			for (a = 1; a <= 8; a++) begin
				raw = char_at(seq_lines[a], 28);
				check($sformatf("binary field of line %0d", a), {1'b0, raw},
					decode_bin(seq_lines[a]), 1'b0);
				check($sformatf("hex field of line %0d", a), {1'b0, raw},
					decode_hex(seq_lines[a]), 1'b0);
				check($sformatf("separators of line %0d", a), {": ", " ", " 0x"},
					{char_at(seq_lines[a], 26), char_at(seq_lines[a], 27),
					char_at(seq_lines[a], 29), char_at(seq_lines[a], 38),
					char_at(seq_lines[a], 39), char_at(seq_lines[a], 40)}, 1'b0);
			end
		end
		end_test("field formats", errs);

		errs = error_count;
		if (!aborted) begin
			reset_and_watch(1'b1, 0, pins);
			wait_program(line_timeout);
			@(posedge clk27);
			write_req <= 1'b0;
			get_line("address 0 after the write", line, len);
			if (!aborted) begin
				check("program count", 1, flash_chip.program_count, 1'b0);
				check("line for address 0 after the write",
					expected_line(24'h0, orig0 & "#"), line, 1'b1);
			end
		end
		end_test("write then read", errs);

		$display("tests run: %0d, tests failed: %0d, errors: %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
source/flash_dump_pkg.sv
source/spi_flash_master.sv
source/uart_tx.sv
source/dump_line_formatter.sv
source/dump_sequencer.sv
source/flash_dump_top.sv
bench/spi_flash_model.sv
bench/tb_flash_dump.sv
